// ==== Makefile ====
# Verilator build and run of the cache testbench
TOP := tb_cache

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check sim.log for the pass line"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cache_assertions.sv ====
`include "cache_defs.svh"

module cache_assertions import cache_pkg::*; (
  input logic         clk,
  input logic         rst_n,
  input cache_state_e state,
  input logic         cpu_req_ready,
  input logic         cpu_res_valid,
  input logic         mem_req_valid,
  input logic         mem_req_write,
  input cache_addr_u  mem_req_addr,
  input logic         mem_req_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // Memory request held steady until mem_req_ready
  mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && !mem_req_ready |=>
      mem_req_valid && $stable(mem_req_addr.raw) && $stable(mem_req_write))
    else $error("memory request dropped or changed before mem_req_ready");

  // Response is a single-cycle pulse
  res_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_res_valid |=> !cpu_res_valid)
    else $error("cpu_res_valid high for more than one cycle");

  // Requests accepted only in IDLE
  ready_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    state != IDLE |-> !cpu_req_ready)
    else $error("cpu_req_ready high outside IDLE");

endmodule

bind cache_fsm cache_assertions u_assertions (
  .clk(clk), .rst_n(rst_n), .state(state),
  .cpu_req_ready(cpu_req_ready), .cpu_res_valid(cpu_res_valid),
  .mem_req_valid(mem_req_valid), .mem_req_write(mem_req_write),
  .mem_req_addr(mem_req_addr), .mem_req_ready(mem_req_ready)
);

// ==== cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Word and block shape
`define CACHE_WORD_W 32                                // Bits per CPU word
`define CACHE_WORDS 4                                  // Words per block
`define CACHE_BLOCK_W (`CACHE_WORDS * `CACHE_WORD_W)   // 128 bit block
`define CACHE_OFS_W 2                                  // Word offset inside a block
`define CACHE_BYTE_W 2                                 // Byte bits below the word offset

// Set and way shape
`define CACHE_SETS 16                                  // Sets per way
`define CACHE_IDX_W 4                                  // log2 of the set count
`define CACHE_WAYS 4                                   // Four way associative

// Address split is tag | index | word offset | byte
`define CACHE_TAG_W (`CACHE_WORD_W - `CACHE_IDX_W - `CACHE_OFS_W - `CACHE_BYTE_W)

// Two bits rank four ways, 0 is most recent
`define CACHE_AGE_W 2

`endif

// ==== cache_fsm.sv ====
`include "cache_defs.svh"

module cache_fsm import cache_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cpu_req_valid,
  input  logic                      cpu_req_write,
  input  cache_addr_u               cpu_req_addr,
  input  logic [`CACHE_WORD_W-1:0]  cpu_req_wdata,
  output logic                      cpu_req_ready,
  output logic                      cpu_res_valid,
  output logic [`CACHE_WORD_W-1:0]  cpu_res_rdata,
  output logic                      mem_req_valid,
  output logic                      mem_req_write,
  output cache_addr_u               mem_req_addr,
  output logic [`CACHE_BLOCK_W-1:0] mem_req_wdata,
  input  logic                      mem_req_ready,
  input  logic [`CACHE_BLOCK_W-1:0] mem_rdata,
  output logic                      sweep_start,
  input  logic [`CACHE_IDX_W-1:0]   sweep_index,
  input  logic                      sweep_done,
  output logic [`CACHE_IDX_W-1:0]   rd_index,
  output logic [`CACHE_IDX_W-1:0]   wr_index,
  output way_oh_t                   meta_we,
  output way_oh_t                   data_we,
  output line_meta_t                new_meta,
  output logic                      age_we,
  output logic [`CACHE_BLOCK_W-1:0] write_block,
  input  logic [`CACHE_BLOCK_W-1:0] blocks [`CACHE_WAYS],
  input  logic                      hit,
  input  way_oh_t                   hit_way,
  input  way_oh_t                   victim_way,
  input  logic                      victim_dirty,
  input  logic [`CACHE_TAG_W-1:0]   victim_tag,
  output cache_addr_u               req_addr,
  output logic                      req_write,
  output logic [`CACHE_WORD_W-1:0]  req_wdata
);

  cache_state_e              state, state_next;
  logic                      sweep_issued;  // One sweep per reset
  logic [`CACHE_BLOCK_W-1:0] hit_block;
  logic [`CACHE_BLOCK_W-1:0] victim_block;

  function automatic logic [`CACHE_WORD_W-1:0] word_of(
    input logic [`CACHE_BLOCK_W-1:0] blk,
    input logic [`CACHE_OFS_W-1:0]   ofs
  );
    return blk[ofs*`CACHE_WORD_W +: `CACHE_WORD_W];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= INIT;
      sweep_issued <= 1'b0;
    end else begin
      state <= state_next;
      if (sweep_start) sweep_issued <= 1'b1;
    end
  end

  // Request held from accept to response
  always_ff @(posedge clk) begin
    if (cpu_req_valid && cpu_req_ready) begin
      req_addr  <= cpu_req_addr;
      req_write <= cpu_req_write;
      req_wdata <= cpu_req_wdata;
    end
  end

  // Read word captured on the way into RESPOND
  always_ff @(posedge clk) begin
    if (state == LOOKUP) cpu_res_rdata <= word_of(hit_block, req_addr.f.ofs);
    else if (state == REFILL && mem_req_ready) cpu_res_rdata <= word_of(mem_rdata, req_addr.f.ofs);
  end

  // One-hot way to block mux
  always_comb begin
    hit_block    = '0;
    victim_block = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (hit_way[w]) hit_block = hit_block | blocks[w];
      if (victim_way[w]) victim_block = victim_block | blocks[w];
    end
  end

  assign sweep_start   = (state == INIT) && !sweep_issued;
  assign cpu_req_ready = (state == IDLE);
  assign cpu_res_valid = (state == RESPOND);
  // Set read starts on the accepting edge
  assign rd_index      = (state == IDLE) ? cpu_req_addr.f.idx : req_addr.f.idx;

  assign mem_req_valid = (state == WRITEBACK) || (state == REFILL);
  assign mem_req_write = (state == WRITEBACK);
  assign mem_req_wdata = victim_block;  // Only sampled in WRITEBACK

  // Block aligned, victim tag for write-back
  always_comb begin
    mem_req_addr            = req_addr;
    mem_req_addr.f.ofs      = '0;
    mem_req_addr.f.byte_ofs = '0;
    if (state == WRITEBACK) mem_req_addr.f.tag = victim_tag;
  end

  always_comb begin
    state_next  = state;
    wr_index    = req_addr.f.idx;
    meta_we     = '0;
    data_we     = '0;
    age_we      = 1'b0;
    new_meta    = '0;
    write_block = mem_rdata;
    case (state)
      INIT: begin
        wr_index = sweep_index;
        if (sweep_done) state_next = IDLE;
        else meta_we = '1;  // All-zero meta clears valid
      end
      IDLE: begin
        if (cpu_req_valid) state_next = LOOKUP;
      end
      LOOKUP: begin
        if (hit) begin
          age_we = 1'b1;  // Hit way becomes most recent
          if (req_write) begin
            meta_we        = hit_way;
            data_we        = hit_way;
            write_block    = hit_block;  // Store merges the new word in
            new_meta.valid = 1'b1;
            new_meta.dirty = 1'b1;
            new_meta.tag   = req_addr.f.tag;
          end
          state_next = RESPOND;
        end else if (victim_dirty) begin
          state_next = WRITEBACK;
        end else begin
          state_next = REFILL;
        end
      end
      WRITEBACK: begin
        if (mem_req_ready) state_next = REFILL;
      end
      REFILL: begin
        if (mem_req_ready) begin
          // Refilled block goes to the victim, write miss allocates dirty
          meta_we        = victim_way;
          data_we        = victim_way;
          age_we         = 1'b1;
          new_meta.valid = 1'b1;
          new_meta.dirty = req_write;
          new_meta.tag   = req_addr.f.tag;
          state_next     = RESPOND;
        end
      end
      RESPOND: state_next = IDLE;
      default: state_next = INIT;
    endcase
  end

endmodule

// ==== cache_pkg.sv ====
`include "cache_defs.svh"

package cache_pkg;

  // Controller states
  typedef enum logic [2:0] {
    INIT,       // Invalidate sweep after reset
    IDLE,       // Ready for a CPU request
    LOOKUP,     // Set read back, tag compare
    WRITEBACK,  // Dirty victim out to memory
    REFILL,     // Block fetch from memory
    RESPOND     // One cycle response pulse
  } cache_state_e;

  // Field view of a CPU address, MSB first
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]  tag;
    logic [`CACHE_IDX_W-1:0]  idx;
    logic [`CACHE_OFS_W-1:0]  ofs;
    logic [`CACHE_BYTE_W-1:0] byte_ofs;
  } addr_fields_t;

  // Same word seen raw or split into fields
  typedef union packed {
    logic [`CACHE_WORD_W-1:0] raw;
    addr_fields_t             f;
  } cache_addr_u;

  // Per way line state
  typedef struct packed {
    logic                    valid;
    logic                    dirty;
    logic [`CACHE_AGE_W-1:0] age;   // LRU rank
    logic [`CACHE_TAG_W-1:0] tag;
  } line_meta_t;

  typedef logic [`CACHE_WAYS-1:0] way_oh_t;  // One bit per way

endpackage

// ==== cache_top.sv ====
`include "cache_defs.svh"

module cache_top import cache_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  // CPU word port
  input  logic                      cpu_req_valid,
  input  logic                      cpu_req_write,
  input  cache_addr_u               cpu_req_addr,
  input  logic [`CACHE_WORD_W-1:0]  cpu_req_wdata,
  output logic                      cpu_req_ready,
  output logic                      cpu_res_valid,
  output logic [`CACHE_WORD_W-1:0]  cpu_res_rdata,
  // Memory block port
  output logic                      mem_req_valid,
  output logic                      mem_req_write,
  output cache_addr_u               mem_req_addr,
  output logic [`CACHE_BLOCK_W-1:0] mem_req_wdata,
  input  logic                      mem_req_ready,
  input  logic [`CACHE_BLOCK_W-1:0] mem_rdata
);

  // Sweep counter
  logic                      sweep_start;
  logic                      sweep_done;
  logic [`CACHE_IDX_W-1:0]   sweep_index;

  // Array access
  logic [`CACHE_IDX_W-1:0]   rd_index;
  logic [`CACHE_IDX_W-1:0]   wr_index;
  way_oh_t                   meta_we;
  way_oh_t                   data_we;
  line_meta_t                new_meta;
  logic                      age_we;
  logic [`CACHE_BLOCK_W-1:0] write_block;
  line_meta_t                metas [`CACHE_WAYS];
  logic [`CACHE_BLOCK_W-1:0] blocks [`CACHE_WAYS];

  // Lookup results
  logic                      hit;
  way_oh_t                   hit_way;
  way_oh_t                   victim_way;
  logic                      victim_dirty;
  logic [`CACHE_TAG_W-1:0]   victim_tag;
  logic [`CACHE_AGE_W-1:0]   new_ages [`CACHE_WAYS];

  // Held CPU request
  cache_addr_u               req_addr;
  logic                      req_write;
  logic [`CACHE_WORD_W-1:0]  req_wdata;

  cache_fsm u_fsm (
    .clk, .rst_n,
    .cpu_req_valid, .cpu_req_write, .cpu_req_addr, .cpu_req_wdata,
    .cpu_req_ready, .cpu_res_valid, .cpu_res_rdata,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata,
    .mem_req_ready, .mem_rdata,
    .sweep_start, .sweep_index, .sweep_done,
    .rd_index, .wr_index, .meta_we, .data_we, .new_meta, .age_we,
    .write_block, .blocks,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .req_addr, .req_write, .req_wdata
  );

  set_init_counter u_sweep (
    .clk, .rst_n, .sweep_start, .sweep_index, .sweep_done
  );

  way_lookup u_lookup (
    .metas, .req_tag(req_addr.f.tag),
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .new_ages
  );

  // Word merge follows the held request
  line_store u_store (
    .clk, .rst_n, .rd_index, .wr_index,
    .meta_we, .new_meta, .age_we, .new_ages,
    .data_we, .write_block,
    .merge_en(req_write), .merge_offset(req_addr.f.ofs), .merge_word(req_wdata),
    .metas, .blocks
  );

endmodule

// ==== line_store.sv ====
`include "cache_defs.svh"

module line_store import cache_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`CACHE_IDX_W-1:0]   rd_index,
  input  logic [`CACHE_IDX_W-1:0]   wr_index,
  input  way_oh_t                   meta_we,
  input  line_meta_t                new_meta,
  input  logic                      age_we,
  input  logic [`CACHE_AGE_W-1:0]   new_ages [`CACHE_WAYS],
  input  way_oh_t                   data_we,
  input  logic [`CACHE_BLOCK_W-1:0] write_block,
  input  logic                      merge_en,
  input  logic [`CACHE_OFS_W-1:0]   merge_offset,
  input  logic [`CACHE_WORD_W-1:0]  merge_word,
  output line_meta_t                metas [`CACHE_WAYS],
  output logic [`CACHE_BLOCK_W-1:0] blocks [`CACHE_WAYS]
);

  line_meta_t                meta_mem [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_BLOCK_W-1:0] data_mem [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_BLOCK_W-1:0] merged;

  // CPU word dropped into its slot of the block
  always_comb begin
    merged = write_block;
    if (merge_en) merged[merge_offset*`CACHE_WORD_W +: `CACHE_WORD_W] = merge_word;
  end

  // Metadata writes
  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (meta_we[w]) meta_mem[w][wr_index] <= new_meta;
      // Whole set re-ranked, overrides the age in new_meta
      if (age_we) meta_mem[w][wr_index].age <= new_ages[w];
    end
  end

  // Block writes
  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (data_we[w]) data_mem[w][wr_index] <= merged;
    end
  end

  // Registered set read, metadata reads back invalid out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        metas[w] <= '0;
      end
    end else begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        metas[w] <= meta_mem[w][rd_index];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      blocks[w] <= data_mem[w][rd_index];  // Old data if written on this edge
    end
  end

endmodule

// ==== set_init_counter.sv ====
`include "cache_defs.svh"

module set_init_counter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sweep_start,
  output logic [`CACHE_IDX_W-1:0] sweep_index,
  output logic                    sweep_done
);

  logic busy;
  logic last;

  assign last = (sweep_index == `CACHE_IDX_W'(`CACHE_SETS - 1));

  // Index rests at 0 between sweeps, so the start cycle itself covers set 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep_index <= '0;
      busy        <= 1'b0;
      sweep_done  <= 1'b0;
    end else begin
      if (sweep_start || busy) sweep_index <= sweep_index + 1'b1;  // Wraps back to 0
      if (sweep_start) begin
        busy       <= 1'b1;
        sweep_done <= 1'b0;
      end else if (busy && last) begin
        busy       <= 1'b0;
        sweep_done <= 1'b1;  // Held until the next start
      end
    end
  end

endmodule

// ==== sim.f ====
+incdir+.
cache_pkg.sv
set_init_counter.sv
way_lookup.sv
line_store.sv
cache_fsm.sv
cache_top.sv
cache_assertions.sv
tb_cache.sv

// ==== tb_cache.sv ====
`include "cache_defs.svh"

module tb_cache import cache_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'hd12f4efa;
  // About 230 accesses, each under 30 cycles with the slowest memory, plus reset
  localparam int CYCLE_LIMIT = 20000;

  logic                      clk;
  logic                      rst_n;
  logic                      cpu_req_valid;
  logic                      cpu_req_write;
  cache_addr_u               cpu_req_addr;
  logic [`CACHE_WORD_W-1:0]  cpu_req_wdata;
  logic                      cpu_req_ready;
  logic                      cpu_res_valid;
  logic [`CACHE_WORD_W-1:0]  cpu_res_rdata;
  logic                      mem_req_valid;
  logic                      mem_req_write;
  cache_addr_u               mem_req_addr;
  logic [`CACHE_BLOCK_W-1:0] mem_req_wdata;
  logic                      mem_req_ready;
  logic [`CACHE_BLOCK_W-1:0] mem_rdata;

  int errors;
  int checks;
  int tests;
  int cycles;
  logic [31:0] traffic_seed;
  logic [31:0] mem_seed;
  logic [`CACHE_WORD_W-1:0]  ref_words [logic [31:0]];   // Words the CPU has written
  logic [`CACHE_BLOCK_W-1:0] mem_blocks [logic [31:0]];  // Blocks written back
  cache_addr_u               rd_addrs [$];               // Refill log
  cache_addr_u               wb_addrs [$];               // Write-back log
  logic [`CACHE_BLOCK_W-1:0] wb_blocks [$];

  cache_top UUT (
    .clk, .rst_n,
    .cpu_req_valid, .cpu_req_write, .cpu_req_addr, .cpu_req_wdata,
    .cpu_req_ready, .cpu_res_valid, .cpu_res_rdata,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata,
    .mem_req_ready, .mem_rdata
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory content before any write-back, odd multiplier keeps every address bit
  function automatic logic [31:0] mem_init_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h3c5a_a5c3;
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    logic [31:0] key;
    key = {addr[31:2], 2'b00};
    if (ref_words.exists(key)) return ref_words[key];
    return mem_init_word(key);
  endfunction

  function automatic cache_addr_u addr_of(input logic [`CACHE_TAG_W-1:0] tag,
                                          input logic [`CACHE_IDX_W-1:0] idx,
                                          input logic [`CACHE_OFS_W-1:0] ofs);
    cache_addr_u a;
    a.raw   = '0;
    a.f.tag = tag;
    a.f.idx = idx;
    a.f.ofs = ofs;
    return a;
  endfunction

  function automatic cache_addr_u block_of(input cache_addr_u a);
    cache_addr_u b;
    b            = a;
    b.f.ofs      = '0;  // Block aligned
    b.f.byte_ofs = '0;
    return b;
  endfunction

  function automatic logic [`CACHE_BLOCK_W-1:0] mem_block_read(input logic [31:0] base);
    logic [`CACHE_BLOCK_W-1:0] blk;
    if (mem_blocks.exists(base)) return mem_blocks[base];
    for (int i = 0; i < `CACHE_WORDS; i++) begin
      blk[i*32 +: 32] = mem_init_word(base + 32'(i * 4));  // Word 0 in the low bits
    end
    return blk;
  endfunction

  task automatic compare_word(input string name, input logic [`CACHE_WORD_W-1:0] got, want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic compare_addr(input string name, input cache_addr_u got, want);
    checks++;
    if (got.raw !== want.raw) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got.raw, want.raw);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("ERROR %0t %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int errs0);
    tests++;
    if (errors == errs0) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, errors - errs0);
  endtask

  task automatic clear_log();
    rd_addrs.delete();
    wb_addrs.delete();
    wb_blocks.delete();
  endtask

  // One request, latency counts falling edges from acceptance to the response
  task automatic cpu_access(input logic wr, input cache_addr_u addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int latency);
    @(posedge clk);
    cpu_req_valid <= 1'b1;
    cpu_req_write <= wr;
    cpu_req_addr  <= addr;
    cpu_req_wdata <= wdata;
    do @(posedge clk); while (!cpu_req_ready);  // Accepted on this edge
    cpu_req_valid <= 1'b0;
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (!cpu_res_valid && latency < 200);
    rdata = cpu_res_rdata;
    if (!cpu_res_valid) note_failure($sformatf("no response for address %h", addr.raw));
  endtask

  task automatic do_read(input cache_addr_u addr, output int latency);
    logic [31:0] rd;
    cpu_access(1'b0, addr, 32'd0, rd, latency);
    compare_word("cpu_res_rdata", rd, ref_read(addr.raw));
  endtask

  task automatic do_write(input cache_addr_u addr, input logic [31:0] data);
    logic [31:0] rd;
    int          lat;
    cpu_access(1'b1, addr, data, rd, lat);
    ref_words[{addr.raw[31:2], 2'b00}] = data;
  endtask

  task automatic test_reset();
    int errs0;
    int n;
    errs0 = errors;
    repeat (16) begin
      @(negedge clk);
      compare_word("cpu_req_ready", 32'(cpu_req_ready), 32'd0);
      compare_word("cpu_res_valid", 32'(cpu_res_valid), 32'd0);
      compare_word("mem_req_valid", 32'(mem_req_valid), 32'd0);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cpu_req_ready && n < 40);
    if (n > 20) note_failure($sformatf("cpu_req_ready rose %0d cycles after reset", n));
    finish_test("reset and init", errs0);
  endtask

  task automatic test_read_hit();
    int          errs0;
    int          lat;
    cache_addr_u a;
    errs0 = errors;
    a     = addr_of(24'h000100, 4'd3, 2'd1);
    clear_log();
    do_read(a, lat);  // Cold miss
    if (rd_addrs.size() != 1) note_failure($sformatf("%0d refills for one miss", rd_addrs.size()));
    else compare_addr("mem_req_addr", rd_addrs[0], block_of(a));
    clear_log();
    do_read(addr_of(24'h000100, 4'd3, 2'd2), lat);  // Same block
    if (rd_addrs.size() != 0 || wb_addrs.size() != 0) note_failure("read hit went to memory");
    if (lat != 2) note_failure($sformatf("read hit answered after %0d edges", lat));
    finish_test("read miss then hit", errs0);
  endtask

  task automatic test_write();
    int errs0;
    int lat;
    errs0 = errors;
    do_read(addr_of(24'h000200, 4'd5, 2'd0), lat);
    do_write(addr_of(24'h000200, 4'd5, 2'd2), 32'hdead_0001);  // Write hit
    do_write(addr_of(24'h000300, 4'd6, 2'd1), 32'hbeef_0002);  // Write miss allocates
    for (int w = 0; w < `CACHE_WORDS; w++) begin
      do_read(addr_of(24'h000200, 4'd5, 2'(w)), lat);
      do_read(addr_of(24'h000300, 4'd6, 2'(w)), lat);
    end
    finish_test("write hit and miss", errs0);
  endtask

  // Four tags fill the set, the fifth evicts the least recently used first one
  task automatic test_eviction(input logic with_write, input logic [3:0] idx, input string name);
    int          errs0;
    int          lat;
    cache_addr_u first;
    errs0 = errors;
    clear_log();
    first = addr_of(24'h004000, idx, 2'd0);
    do_read(first, lat);
    if (with_write) do_write(addr_of(24'h004000, idx, 2'd3), 32'hc0de_0004);
    for (int t = 1; t < 4; t++) begin
      do_read(addr_of(24'h004000 + 24'(t), idx, 2'd0), lat);
    end
    do_read(addr_of(24'h004004, idx, 2'd0), lat);
    if (with_write && wb_addrs.size() == 1) begin
      compare_addr("mem_req_addr", wb_addrs[0], block_of(first));
      compare_word("mem_req_wdata", wb_blocks[0][3*32 +: 32], 32'hc0de_0004);
    end else if (wb_addrs.size() != (with_write ? 1 : 0)) begin
      note_failure($sformatf("%0d write-backs seen", wb_addrs.size()));
    end
    finish_test(name, errs0);
  endtask

  task automatic test_random();
    int          errs0;
    int          lat;
    cache_addr_u a;
    logic [31:0] data;
    errs0 = errors;
    for (int n = 0; n < 200; n++) begin
      traffic_seed = lcg_next(traffic_seed);
      // Sets 0 to 2, six tags each, upper LCG bits only
      a = addr_of(24'h006000 + 24'(traffic_seed[23:16] % 8'd6),
                  4'(traffic_seed[31:24] % 8'd3), traffic_seed[13:12]);
      if (traffic_seed[10]) begin
        data         = lcg_next(traffic_seed);
        traffic_seed = data;
        do_write(a, data);
      end else begin
        do_read(a, lat);
      end
    end
    finish_test("mixed random traffic", errs0);
  endtask

  // Memory model, answers each block request after a short random wait
  initial begin
    logic [31:0] base;
    logic        busy;
    logic [1:0]  wait_left;
    mem_req_ready <= 1'b0;
    mem_rdata     <= '0;
    mem_seed  = SEED;
    busy      = 1'b0;
    wait_left = 2'd0;
    forever begin
      @(posedge clk);
      if (mem_req_ready) begin
        mem_req_ready <= 1'b0;  // Request completes on this edge
        busy = 1'b0;
      end else if (mem_req_valid) begin
        if (!busy) begin
          busy      = 1'b1;
          mem_seed  = lcg_next(mem_seed);
          wait_left = mem_seed[31:30];
        end
        if (wait_left != 2'd0) begin
          wait_left = wait_left - 2'd1;
        end else begin
          base = mem_req_addr.raw;
          if (mem_req_write) begin
            wb_addrs.push_back(mem_req_addr);
            wb_blocks.push_back(mem_req_wdata);
            for (int i = 0; i < `CACHE_WORDS; i++) begin
              compare_word("mem_req_wdata", mem_req_wdata[i*32 +: 32], ref_read(base + 32'(i * 4)));
            end
            mem_blocks[base] = mem_req_wdata;
          end else begin
            rd_addrs.push_back(mem_req_addr);
            mem_rdata <= mem_block_read(base);  // Valid in the ready cycle
          end
          mem_req_ready <= 1'b1;
        end
      end
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst_n         <= 1'b0;
    cpu_req_valid <= 1'b0;
    cpu_req_write <= 1'b0;
    cpu_req_addr  <= '0;
    cpu_req_wdata <= '0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    traffic_seed = SEED;
    test_reset();
    test_read_hit();
    test_write();
    test_eviction(1'b1, 4'd9, "dirty eviction");
    test_eviction(1'b0, 4'd10, "clean eviction");
    test_random();
    $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("All tests passed");
    else $display("Some tests failed");
    $finish;
  end

endmodule

// ==== way_lookup.sv ====
`include "cache_defs.svh"

module way_lookup import cache_pkg::*; (
  input  line_meta_t              metas [`CACHE_WAYS],
  input  logic [`CACHE_TAG_W-1:0] req_tag,
  output logic                    hit,
  output way_oh_t                 hit_way,
  output way_oh_t                 victim_way,
  output logic                    victim_dirty,
  output logic [`CACHE_TAG_W-1:0] victim_tag,
  output logic [`CACHE_AGE_W-1:0] new_ages [`CACHE_WAYS]
);

  way_oh_t touched;

  // Tag compare per way
  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_way[w] = metas[w].valid && (metas[w].tag == req_tag);
    end
  end
  assign hit = |hit_way;

  // Victim is the lowest free way, else the oldest
  always_comb begin
    logic                    found;
    logic [`CACHE_AGE_W-1:0] oldest;
    found      = 1'b0;
    oldest     = '0;
    victim_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!metas[w].valid && !found) begin
        victim_way = way_oh_t'(1 << w);
        found      = 1'b1;
      end
    end
    if (!found) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (w == 0 || metas[w].age > oldest) begin
          victim_way = way_oh_t'(1 << w);
          oldest     = metas[w].age;
        end
      end
    end
  end

  always_comb begin
    victim_dirty = 1'b0;
    victim_tag   = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (victim_way[w]) begin
        victim_dirty = metas[w].valid && metas[w].dirty;  // Needs write-back
        victim_tag   = metas[w].tag;
      end
    end
  end

  assign touched = hit ? hit_way : victim_way;

  // Touched way to 0, younger ways age by one
  always_comb begin
    logic [`CACHE_AGE_W-1:0] pivot;
    // Filling a free way ages every valid way, so valid ages stay 0..n-1
    pivot = '1;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (touched[w] && metas[w].valid) pivot = metas[w].age;
    end
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (touched[w]) new_ages[w] = '0;
      else if (metas[w].age < pivot) new_ages[w] = metas[w].age + 1'b1;
      else new_ages[w] = metas[w].age;
    end
  end

endmodule
